//--- Makefile
# Verilator build and run for the softmax normalizer

SRCS := $(shell cat filelist.f)

all: run

obj_dir/Vsoftmax_tb: filelist.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module softmax_tb -f filelist.f -Mdir obj_dir

run: obj_dir/Vsoftmax_tb
	./obj_dir/Vsoftmax_tb | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- filelist.f
rtl/softmax_pkg.sv
rtl/sync_fifo.sv
rtl/node_count_table.sv
rtl/pow2_accum.sv
rtl/fxp_div_pipe.sv
rtl/softmax_ctrl.sv
rtl/softmax_top.sv
sim/softmax_tb.sv

//--- rtl/fxp_div_pipe.sv
// Pipelined restoring divider
module fxp_div_pipe (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          vld,
  input  softmax_pkg::term_t            dividend,
  input  logic [softmax_pkg::sum_w-1:0] divisor,
  output logic                          out_vld,
  output softmax_pkg::alpha_t           quotient
);

  localparam int nstage = softmax_pkg::div_latency;
  localparam int aw     = softmax_pkg::alpha_w;
  localparam int num_w  = softmax_pkg::term_w + softmax_pkg::wof;
  localparam int rem_w  = softmax_pkg::sum_w + 1;

  typedef logic [rem_w-1:0] rem_t;

  logic [num_w-1:0]              num;
  logic [nstage-1:0]             s_vld;
  rem_t                          s_rem  [0:nstage-1];
  logic [aw-1:0]                 s_low  [0:nstage-1];
  logic [softmax_pkg::sum_w-1:0] s_dvsr [0:nstage-1];
  softmax_pkg::alpha_t           s_quo  [0:nstage-1];
  rem_t                          trial  [0:aw-1];
  logic                          take   [0:aw-1];

  // Dividend scaled by 2^wof
  assign num = {dividend, {softmax_pkg::wof{1'b0}}};

  // ====================================================================
  // Bit stages
  // ====================================================================

  // Partial remainder shifted left with the next numerator bit
  for (genvar i = 0; i < aw; i++) begin : g_bit
    assign trial[i] = {s_rem[i][rem_w-2:0], s_low[i][aw-1]};
    assign take[i]  = (trial[i] >= rem_t'(s_dvsr[i]));
  end

  // Valid chain, one bit per stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_vld <= '0;
    end else begin
      s_vld <= {s_vld[nstage-2:0], vld};
    end
  end

  always_ff @(posedge clk) begin
    // Input stage
    // Upper numerator bits stay below the divisor since each term
    // is part of its own group sum, so only aw quotient bits remain
    s_rem[0]  <= rem_t'(num[num_w-1:aw]);
    s_low[0]  <= num[aw-1:0];
    s_dvsr[0] <= divisor;
    s_quo[0]  <= '0;

    for (int i = 0; i < aw; i++) begin
      if (take[i]) begin
        s_rem[i+1] <= trial[i] - rem_t'(s_dvsr[i]);
      end else begin
        s_rem[i+1] <= trial[i];
      end
      s_low[i+1]  <= s_low[i] << 1;
      // Divisor travels with its item
      s_dvsr[i+1] <= s_dvsr[i];
      s_quo[i+1]  <= {s_quo[i][aw-2:0], take[i]};
    end
  end

  // ====================================================================
  // Result
  // ====================================================================
  assign out_vld  = s_vld[nstage-1];
  assign quotient = s_quo[nstage-1];

endmodule

//--- rtl/node_count_table.sv
// Nodes per subgraph table
module node_count_table #(
  parameter  int num_groups = 8,
  localparam int grp_w      = (num_groups > 1) ? $clog2(num_groups) : 1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wr,
  input  logic [grp_w-1:0]               waddr,
  input  logic [softmax_pkg::node_w-1:0] wdata,
  input  logic [grp_w-1:0]               raddr,
  output logic [softmax_pkg::node_w-1:0] rdata
);

  logic [softmax_pkg::node_w-1:0] entry [0:num_groups-1];

  // Writes beyond num_groups are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_groups; i++) begin
        entry[i] <= '1;
      end
    end else if (wr && (int'(waddr) < num_groups)) begin
      entry[waddr] <= wdata;
    end
  end

  // Read in the same cycle as the address
  assign rdata = entry[raddr];

endmodule

//--- rtl/pow2_accum.sv
// Power-of-two term and subgraph sum
module pow2_accum (
  input  logic                          clk,
  input  logic                          rst_n,
  input  softmax_pkg::coef_t            coef,
  input  logic                          acc_en,
  input  logic                          acc_first,
  output softmax_pkg::term_t            term,
  output logic [softmax_pkg::sum_w-1:0] sum_next
);

  typedef logic [softmax_pkg::sum_w-1:0] sum_t;

  sum_t sum_q;
  sum_t base;

  // ====================================================================
  // Term
  // ====================================================================

  // Exact for every exponent up to term_w-1
  assign term = softmax_pkg::term_t'(1) << coef;

  // ====================================================================
  // Running sum
  // ====================================================================

  // First node of a group restarts from zero
  assign base     = acc_first ? '0 : sum_q;
  assign sum_next = base + sum_t'(term);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_q <= '0;
    end else if (acc_en) begin
      sum_q <= sum_next;
    end
  end

endmodule

//--- rtl/softmax_ctrl.sv
// Softmax control
module softmax_ctrl #(
  parameter  int num_groups = 8,
  localparam int grp_w      = (num_groups > 1) ? $clog2(num_groups) : 1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           sm_en,
  input  logic                           coef_empty,
  input  logic [softmax_pkg::node_w-1:0] num_node,
  input  logic                           term_full,
  input  logic                           sum_full,
  input  logic                           sum_empty,
  input  softmax_pkg::sum_rec_t          sum_rec,
  input  logic                           alpha_full,
  output logic                           coef_rd,
  output logic [grp_w-1:0]               tbl_raddr,
  output logic                           acc_en,
  output logic                           acc_first,
  output logic                           term_push,
  output logic                           sum_push,
  output logic                           term_pop,
  output logic                           sum_pop,
  output logic                           div_vld,
  output logic [softmax_pkg::sum_w-1:0]  divisor
);

  typedef logic [softmax_pkg::node_w-1:0] node_t;
  typedef logic [grp_w-1:0]               grp_t;

  // Input side
  node_t in_cnt;
  grp_t  grp_idx;
  logic  in_last;

  // Output side
  node_t                         out_left;
  logic [softmax_pkg::sum_w-1:0] div_sum;
  logic                          grp_start;
  logic                          grp_cont;

  // ====================================================================
  // Coefficient side
  // ====================================================================

  // Stall upstream instead of dropping when a queue fills
  assign coef_rd   = sm_en && !coef_empty && !term_full && !sum_full;
  assign in_last   = ((in_cnt + node_t'(1)) == num_node);
  assign tbl_raddr = grp_idx;

  assign acc_en    = coef_rd;
  assign acc_first = (in_cnt == '0);
  assign term_push = coef_rd;
  // Record goes in together with the last term of the group
  assign sum_push  = coef_rd && in_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_cnt  <= '0;
      grp_idx <= '0;
    end else if (coef_rd) begin
      if (in_last) begin
        in_cnt <= '0;
        if (grp_idx == grp_t'(num_groups - 1)) begin
          grp_idx <= '0;
        end else begin
          grp_idx <= grp_idx + grp_t'(1);
        end
      end else begin
        in_cnt <= in_cnt + node_t'(1);
      end
    end
  end

  // ====================================================================
  // Divide side
  // ====================================================================

  // A waiting record means its terms are already queued
  assign grp_start = (out_left == '0) && !sum_empty && !alpha_full;
  assign grp_cont  = (out_left != '0) && !alpha_full;

  assign sum_pop  = grp_start;
  assign term_pop = grp_start || grp_cont;
  assign div_vld  = term_pop;

  // First term takes the sum straight from the queue head
  assign divisor = (out_left == '0) ? sum_rec.sum : div_sum;

  // Terms still to issue in the current group
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_left <= '0;
    end else if (grp_start) begin
      out_left <= sum_rec.num_node - node_t'(1);
    end else if (grp_cont) begin
      out_left <= out_left - node_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (grp_start) begin
      div_sum <= sum_rec.sum;
    end
  end

endmodule

//--- rtl/softmax_pkg.sv
// Softmax shared definitions
package softmax_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  localparam int coef_w    = 4;
  localparam int term_w    = 16;
  localparam int max_nodes = 16;

  // Counts run 1 to max_nodes, so one extra bit
  localparam int node_w = $clog2(max_nodes) + 1;

  // Room for max_nodes terms of 2^(term_w-1)
  localparam int sum_w = term_w + $clog2(max_nodes) + 1;

  // Result format, one integer bit for the single node case
  localparam int woi     = 1;
  localparam int wof     = 15;
  localparam int alpha_w = woi + wof;

  // Input register plus one stage per quotient bit
  localparam int div_latency = alpha_w + 1;

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic [coef_w-1:0]  coef_t;
  typedef logic [term_w-1:0]  term_t;
  typedef logic [alpha_w-1:0] alpha_t;

  // One record per subgraph
  typedef struct packed {
    logic [node_w-1:0] num_node;
    logic [sum_w-1:0]  sum;
  } sum_rec_t;

endpackage

//--- rtl/softmax_top.sv
// Softmax normalizer top level
module softmax_top #(
  parameter  int num_groups  = 8,
  parameter  int queue_depth = 32,
  localparam int grp_w       = (num_groups > 1) ? $clog2(num_groups) : 1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           sm_en,
  input  softmax_pkg::coef_t             coef_data,
  input  logic                           coef_empty,
  output logic                           coef_rd,
  input  logic                           tbl_wr,
  input  logic [grp_w-1:0]               tbl_addr,
  input  logic [softmax_pkg::node_w-1:0] tbl_data,
  output softmax_pkg::alpha_t            alpha_data,
  output logic                           alpha_wr,
  input  logic                           alpha_full
);

  logic [grp_w-1:0]               tbl_raddr;
  logic [softmax_pkg::node_w-1:0] num_node;
  logic                           acc_en;
  logic                           acc_first;
  softmax_pkg::term_t             term;
  logic [softmax_pkg::sum_w-1:0]  sum_next;

  // Queue controls
  logic                           term_push;
  logic                           term_pop;
  logic                           term_full;
  softmax_pkg::term_t             term_head;
  logic                           sum_push;
  logic                           sum_pop;
  logic                           sum_full;
  logic                           sum_empty;
  softmax_pkg::sum_rec_t          sum_rec_in;
  softmax_pkg::sum_rec_t          sum_rec;

  logic                           div_vld;
  logic [softmax_pkg::sum_w-1:0]  divisor;

  assign sum_rec_in.num_node = num_node;
  assign sum_rec_in.sum      = sum_next;

  softmax_ctrl #(.num_groups(num_groups)) u_ctrl (
    .clk(clk), .rst_n(rst_n), .sm_en(sm_en), .coef_empty(coef_empty),
    .num_node(num_node), .term_full(term_full), .sum_full(sum_full),
    .sum_empty(sum_empty), .sum_rec(sum_rec), .alpha_full(alpha_full),
    .coef_rd(coef_rd), .tbl_raddr(tbl_raddr), .acc_en(acc_en),
    .acc_first(acc_first), .term_push(term_push), .sum_push(sum_push),
    .term_pop(term_pop), .sum_pop(sum_pop), .div_vld(div_vld), .divisor(divisor)
  );

  node_count_table #(.num_groups(num_groups)) u_table (
    .clk(clk), .rst_n(rst_n), .wr(tbl_wr), .waddr(tbl_addr), .wdata(tbl_data),
    .raddr(tbl_raddr), .rdata(num_node)
  );

  pow2_accum u_accum (
    .clk(clk), .rst_n(rst_n), .coef(coef_data), .acc_en(acc_en),
    .acc_first(acc_first), .term(term), .sum_next(sum_next)
  );

  // ====================================================================
  // Buffer queues
  // ====================================================================
  sync_fifo #(.payload_t(softmax_pkg::term_t), .depth(queue_depth)) term_q (
    .clk(clk), .rst_n(rst_n), .din(term), .push(term_push), .pop(term_pop),
    .dout(term_head), .full(term_full), .empty()
  );

  sync_fifo #(.payload_t(softmax_pkg::sum_rec_t), .depth(queue_depth)) sum_q (
    .clk(clk), .rst_n(rst_n), .din(sum_rec_in), .push(sum_push), .pop(sum_pop),
    .dout(sum_rec), .full(sum_full), .empty(sum_empty)
  );

  // Results go straight to the downstream FIFO
  fxp_div_pipe u_div (
    .clk(clk), .rst_n(rst_n), .vld(div_vld), .dividend(term_head),
    .divisor(divisor), .out_vld(alpha_wr), .quotient(alpha_data)
  );

endmodule

//--- rtl/sync_fifo.sv
// Show-ahead synchronous FIFO
module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 32
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t din,
  input  logic     push,
  input  logic     pop,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [0:depth-1];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + ptr_w'(1);
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == cnt_w'(depth));
  assign empty   = (count == '0);

  // Head entry is visible before the pop
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + cnt_w'(1);
      end else if (do_pop && !do_push) begin
        count <= count - cnt_w'(1);
      end
    end
  end

endmodule

//--- sim/softmax_tb.sv
// Softmax normalizer testbench
module softmax_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_groups  = 8;
  localparam int queue_depth = 32;
  localparam int grp_w       = $clog2(num_groups);
  localparam int mem_size    = 1024;
  localparam int free_margin = 20;
  localparam int settle      = softmax_pkg::div_latency + 4;

  typedef logic [softmax_pkg::node_w-1:0] node_t;

  logic                clk;
  logic                rst_n;
  logic                sm_en      = 1'b0;
  softmax_pkg::coef_t  coef_data  = '0;
  logic                coef_empty = 1'b1;
  logic                coef_rd;
  logic                tbl_wr;
  logic [grp_w-1:0]    tbl_addr;
  node_t               tbl_data;
  softmax_pkg::alpha_t alpha_data;
  logic                alpha_wr;
  logic                alpha_full = 1'b0;

  // Upstream coefficients and expected results as ring buffers
  softmax_pkg::coef_t  up_mem  [0:mem_size-1];
  softmax_pkg::alpha_t exp_mem [0:mem_size-1];
  int up_wr  = 0;
  int up_rd  = 0;
  int exp_wr = 0;
  int exp_rd = 0;

  // Downstream FIFO model
  int down_level  = 0;
  int down_cap    = 256;
  int drain_div   = 1;
  int drain_tick  = 0;
  int full_cycles = 0;

  logic   en_req     = 1'b0;
  logic   disturb_en = 1'b0;
  logic   up_gap     = 1'b0;
  int     en_hold    = 0;
  integer seed       = 5923;

  int recv_count   = 0;
  int value_errors = 0;
  int count_errors = 0;
  int other_errors = 0;
  int next_grp     = 0;
  int tbl_mirror [0:num_groups-1];
  softmax_pkg::coef_t coef_buf [0:softmax_pkg::max_nodes-1];

  logic                rd_seen;
  logic                empty_seen;
  logic                en_seen;
  logic                wr_seen;
  softmax_pkg::alpha_t data_seen;

  softmax_top #(.num_groups(num_groups), .queue_depth(queue_depth)) DUT (
    .clk(clk), .rst_n(rst_n), .sm_en(sm_en), .coef_data(coef_data),
    .coef_empty(coef_empty), .coef_rd(coef_rd), .tbl_wr(tbl_wr),
    .tbl_addr(tbl_addr), .tbl_data(tbl_data), .alpha_data(alpha_data),
    .alpha_wr(alpha_wr), .alpha_full(alpha_full)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================================================================
  // Compare tasks and run end
  // ====================================================================
  task automatic check_alpha(input string name, input softmax_pkg::alpha_t got,
                             input softmax_pkg::alpha_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      count_errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Errors: value %0d, count %0d, other %0d",
             value_errors, count_errors, other_errors);
    if (value_errors + count_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // ====================================================================
  // Upstream and downstream FIFO models
  // ====================================================================
  task automatic take_result(input softmax_pkg::alpha_t value);
    if (down_level >= down_cap) begin
      other_errors++;
      $display("Downstream FIFO overflowed at %0t", $time);
    end
    down_level++;
    recv_count++;
    if (exp_rd == exp_wr) begin
      other_errors++;
      $display("A result arrived with no expected value at %0t", $time);
    end else begin
      check_alpha("alpha_data", value, exp_mem[exp_rd % mem_size]);
      exp_rd++;
    end
  endtask

  // Sample before the edge, update just after it
  always begin
    @(negedge clk);
    rd_seen    = coef_rd;
    empty_seen = coef_empty;
    en_seen    = sm_en;
    wr_seen    = alpha_wr;
    data_seen  = alpha_data;
    if (alpha_full) begin
      full_cycles++;
    end
    @(posedge clk);
    #2;
    if (rd_seen) begin
      if (empty_seen || !en_seen) begin
        other_errors++;
        $display("Coefficient read while the upstream FIFO was empty or sm_en was low at %0t",
                 $time);
      end else begin
        up_rd++;
      end
    end
    if (wr_seen) begin
      take_result(data_seen);
    end
    drain_tick++;
    if (drain_tick >= drain_div) begin
      drain_tick = 0;
      if (down_level > 0) begin
        down_level--;
      end
    end
    // Random gaps and short runs with sm_en low
    if (disturb_en) begin
      up_gap = (($random(seed) & 3) == 0);
      if (en_hold > 0) begin
        en_hold--;
      end else if (($random(seed) & 15) == 0) begin
        en_hold = 6;
      end
    end else begin
      up_gap  = 1'b0;
      en_hold = 0;
    end
    sm_en      = en_req && (en_hold == 0);
    coef_empty = up_gap || (up_rd == up_wr);
    coef_data  = up_mem[up_rd % mem_size];
    alpha_full = (down_cap - down_level) < free_margin;
  end

  // ====================================================================
  // Stimulus helpers
  // ====================================================================
  task automatic write_table(input int idx, input int size);
    @(posedge clk);
    #2;
    tbl_wr   = 1'b1;
    tbl_addr = grp_w'(idx);
    tbl_data = node_t'(size);
    @(posedge clk);
    #2;
    tbl_wr = 1'b0;
    tbl_mirror[idx] = size;
  endtask

  // Reference model takes the floor of term * 2^15 / group sum
  task automatic queue_group(input int n);
    longint sum;
    longint term;
    sum = 0;
    for (int i = 0; i < n; i++) begin
      sum += longint'(1) << coef_buf[i];
    end
    for (int i = 0; i < n; i++) begin
      term = longint'(1) << coef_buf[i];
      up_mem[up_wr % mem_size]   = coef_buf[i];
      exp_mem[exp_wr % mem_size] = softmax_pkg::alpha_t'((term << softmax_pkg::wof) / sum);
      up_wr++;
      exp_wr++;
    end
    next_grp = (next_grp + 1) % num_groups;
  endtask

  task automatic random_group(output int n);
    @(posedge clk);
    #1;
    n = tbl_mirror[next_grp];
    for (int i = 0; i < n; i++) begin
      coef_buf[i] = softmax_pkg::coef_t'($random(seed));
    end
    queue_group(n);
  endtask

  // Wait for every queued result, then watch for extras
  task automatic collect_results(input int first, input int nodes, input int limit);
    int cycles;
    cycles = 0;
    while (recv_count < exp_wr && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (recv_count < exp_wr) begin
      other_errors++;
      $display("Timed out waiting for results, %0d of %0d received", recv_count, exp_wr);
      end_run();
    end
    repeat (settle) @(negedge clk);
    check_count("result count", recv_count - first, nodes);
  endtask

  task automatic run_groups(input int limit);
    int first;
    int nodes;
    int n;
    first = exp_wr;
    nodes = 0;
    for (int g = 0; g < num_groups; g++) begin
      random_group(n);
      nodes += n;
    end
    collect_results(first, nodes, limit);
  endtask

  // ====================================================================
  // Tests
  // ====================================================================
  task automatic test_idle_after_reset();
    @(negedge clk);
    en_req = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_flag("coef_rd", coef_rd, 1'b0);
      check_flag("alpha_wr", alpha_wr, 1'b0);
    end
  endtask

  task automatic test_four_nodes();
    int first;
    first = exp_wr;
    write_table(next_grp, 4);
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++) begin
      coef_buf[i] = softmax_pkg::coef_t'(i);
    end
    queue_group(4);
    collect_results(first, 4, 200);
  endtask

  // One node always gets the whole weight
  task automatic test_single_node();
    int first;
    first = exp_wr;
    write_table(next_grp, 1);
    @(posedge clk);
    #1;
    up_mem[up_wr % mem_size]   = softmax_pkg::coef_t'(9);
    exp_mem[exp_wr % mem_size] = 16'h8000;
    up_wr++;
    exp_wr++;
    next_grp = (next_grp + 1) % num_groups;
    collect_results(first, 1, 200);
  endtask

  task automatic test_random_groups();
    int sizes [0:num_groups-1];
    @(posedge clk);
    #1;
    for (int i = 0; i < num_groups; i++) begin
      sizes[i] = ($random(seed) & 15) + 1;
    end
    for (int i = 0; i < num_groups; i++) begin
      write_table(i, sizes[i]);
    end
    run_groups(2000);
  endtask

  task automatic test_stalls();
    @(posedge clk);
    #1;
    disturb_en = 1'b1;
    run_groups(6000);
    @(negedge clk);
    disturb_en = 1'b0;
  endtask

  task automatic test_backpressure();
    @(posedge clk);
    #1;
    down_cap    = 24;
    drain_div   = 8;
    full_cycles = 0;
    run_groups(8000);
    if (full_cycles == 0) begin
      other_errors++;
      $display("alpha_full never rose during the back-pressure test");
    end
    @(posedge clk);
    #1;
    down_cap  = 256;
    drain_div = 1;
  endtask

  initial begin
    rst_n    = 1'b0;
    tbl_wr   = 1'b0;
    tbl_addr = '0;
    tbl_data = '0;
    for (int i = 0; i < num_groups; i++) begin
      tbl_mirror[i] = 0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_idle_after_reset();
    test_four_nodes();
    test_single_node();
    test_random_groups();
    test_stalls();
    test_backpressure();
    end_run();
  end

endmodule
